/* Makefile */
# Verilator build and run of the operand capture testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= operand_tb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

# The simulator's exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* sources.f */
verilog/operand_pkg.sv
verilog/phys_regfile.sv
verilog/read_port_sched.sv
verilog/validate_operand.sv
verilog/operand_station.sv
verilog/operand_top.sv
tb/operand_tb.sv

/* tb/operand_tb.sv */
/*
 * Operand capture testbench
 * Directed tests and a seeded random run against a reference register
 * model, checking the operands of each station when it raises issue
 */
`timescale 1ns/1ps

module operand_tb;
	import operand_pkg::*;

	// ======================================================================
	// Run limits
	// ======================================================================

	// Longest wait for one issue
	localparam int ISSUE_WAIT = 20;
	// Directed tests each fit in 40 cycles, a random round in 50
	localparam int DIRECTED_LEN = 5 * 40;
	localparam int ROUNDS = 40;
	localparam int ROUND_LEN = 50;
	localparam int RUN_LIMIT = 3 + DIRECTED_LEN + ROUNDS * ROUND_LEN;

	logic                            clk = 1'b0;
	logic                            rst;
	logic [NWB-1:0]                  wb_valid;
	pregno_t [NWB-1:0]               wb_preg;
	value_t [NWB-1:0]                wb_val;
	logic [NWB-1:0]                  wb_tag;
	logic [NSTN-1:0]                 dispatch;
	pregno_t [NSTN-1:0][NOPND-1:0]   disp_preg;
	logic [NSTN-1:0][NOPND-1:0]      disp_valid;
	logic [NSTN-1:0]                 issue_ack;
	logic [NSTN-1:0]                 issue;
	value_t [NSTN-1:0][NOPND-1:0]    opnd_val;
	logic [NSTN-1:0][NOPND-1:0]      opnd_tag;

	// Reference register contents, entry zero stays zero
	value_t model_val [NPREG];
	logic   model_tag [NPREG];

	// What each station was dispatched with
	pregno_t          st_preg [NSTN][NOPND];
	logic [NOPND-1:0] st_dv [NSTN];
	logic             st_busy [NSTN];

	integer seed;
	int     cycles = 0;

	operand_top operand_top_inst (
		.clk_i        (clk),
		.rst_i        (rst),
		.wb_valid_i   (wb_valid),
		.wb_preg_i    (wb_preg),
		.wb_val_i     (wb_val),
		.wb_tag_i     (wb_tag),
		.dispatch_i   (dispatch),
		.disp_preg_i  (disp_preg),
		.disp_valid_i (disp_valid),
		.issue_ack_i  (issue_ack),
		.issue_o      (issue),
		.opnd_val_o   (opnd_val),
		.opnd_tag_o   (opnd_tag)
	);

	always #4 clk = ~clk;

	// Global watchdog on the whole run
	always @(posedge clk) begin
		cycles++;
		if (cycles > RUN_LIMIT) begin
			$display("timeout: the run went past %0d cycles without finishing", RUN_LIMIT);
			abort_run();
		end
	end

	// ======================================================================
	// Reporting and checks
	// ======================================================================

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input value_t got, input value_t exp, input string what);
		if (got !== exp) begin
			$display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_tag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Operands dispatched valid and register zero carry zero with tag zero
	task automatic check_station(input int s);
		value_t exp_val;
		logic   exp_tag;
		for (int k = 0; k < NOPND; k++) begin
			if (st_dv[s][k] || st_preg[s][k] == '0) begin
				exp_val = value_zero;
				exp_tag = 1'b0;
			end else begin
				exp_val = model_val[st_preg[s][k]];
				exp_tag = model_tag[st_preg[s][k]];
			end
			check_value(opnd_val[s][k], exp_val, $sformatf("station %0d operand %0d value", s, k));
			check_tag(opnd_tag[s][k], exp_tag, $sformatf("station %0d operand %0d tag", s, k));
		end
	endtask

	// ======================================================================
	// Drive helpers
	// ======================================================================

	// Moves to the next rising edge and drops every strobe
	task automatic tick();
		@(posedge clk);
		wb_valid <= '0;
		dispatch <= '0;
		issue_ack <= '0;
	endtask

	// Called right after tick, the write lands at the following edge
	task automatic wb_set(input int w, input pregno_t p, input value_t v, input logic t);
		wb_valid[w] <= 1'b1;
		wb_preg[w] <= p;
		wb_val[w] <= v;
		wb_tag[w] <= t;
		if (p != '0) begin
			model_val[p] = v;
			model_tag[p] = t;
		end
	endtask

	task automatic dispatch_set(input int s, input pregno_t p0, input pregno_t p1,
	                            input pregno_t p2, input logic [NOPND-1:0] v);
		dispatch[s] <= 1'b1;
		disp_preg[s] <= {p2, p1, p0};
		disp_valid[s] <= v;
		st_preg[s][0] = p0;
		st_preg[s][1] = p1;
		st_preg[s][2] = p2;
		st_dv[s] = v;
		st_busy[s] = 1'b1;
	endtask

	// Samples issue between edges where it is stable
	task automatic wait_issue(input int s);
		int n;
		n = 0;
		@(negedge clk);
		while (!issue[s]) begin
			if (n >= ISSUE_WAIT) begin
				$display("station %0d did not raise issue within %0d cycles", s, ISSUE_WAIT);
				abort_run();
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic ack_stations(input logic [NSTN-1:0] mask);
		tick();
		issue_ack <= mask;
		tick();
		for (int s = 0; s < NSTN; s++) begin
			if (mask[s]) begin
				st_busy[s] = 1'b0;
			end
		end
	endtask

	// True when a busy station names the register in any operand
	function automatic logic in_use(input pregno_t p);
		logic hit;
		hit = 1'b0;
		for (int s = 0; s < NSTN; s++) begin
			for (int k = 0; k < NOPND; k++) begin
				if (st_busy[s] && st_preg[s][k] == p) begin
					hit = 1'b1;
				end
			end
		end
		return hit;
	endfunction

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_all_valid();
		@(negedge clk);
		check_tag(issue[0], 1'b0, "station 0 issue after reset");
		check_tag(issue[1], 1'b0, "station 1 issue after reset");
		// Nonzero contents that operands dispatched valid must not pick up
		tick();
		wb_set(0, 6'd5, 32'h0bad_0005, 1'b1);
		wb_set(1, 6'd9, 32'h0bad_0009, 1'b1);
		tick();
		dispatch_set(0, 6'd5, 6'd9, 6'd0, 3'b111);
		tick();
		wait_issue(0);
		check_station(0);
		ack_stations(2'b01);
	endtask

	task automatic test_written_regs();
		tick();
		wb_set(0, 6'd10, 32'h1111_000a, 1'b1);
		wb_set(1, 6'd11, 32'h2222_000b, 1'b0);
		tick();
		wb_set(0, 6'd12, 32'h3333_000c, 1'b1);
		tick();
		dispatch_set(1, 6'd10, 6'd11, 6'd12, 3'b000);
		tick();
		wait_issue(1);
		check_station(1);
		ack_stations(2'b10);
	endtask

	// Register zero resolves without a read port
	task automatic test_reg_zero();
		tick();
		dispatch_set(0, 6'd0, 6'd10, 6'd12, 3'b000);
		tick();
		wait_issue(0);
		check_station(0);
		ack_stations(2'b01);
	endtask

	// The writeback arrives in the first busy cycle, ahead of the read return
	task automatic test_bypass_wakeup();
		tick();
		dispatch_set(1, 6'd33, 6'd0, 6'd11, 3'b000);
		tick();
		wb_set(0, 6'd33, 32'hcafe_0033, 1'b1);
		@(negedge clk);
		check_tag(issue[1], 1'b0, "station 1 issue before wakeup");
		tick();
		wait_issue(1);
		check_station(1);
		ack_stations(2'b10);
	endtask

	// Six pending operands compete for four read ports
	task automatic test_port_contention();
		for (int r = 21; r < 27; r += 2) begin
			tick();
			wb_set(0, pregno_t'(r), value_t'(r) ^ 32'h5a00_0000, 1'b1);
			wb_set(1, pregno_t'(r + 1), value_t'(r + 1) ^ 32'ha500_0000, 1'b0);
		end
		tick();
		dispatch_set(0, 6'd21, 6'd22, 6'd23, 3'b000);
		dispatch_set(1, 6'd24, 6'd25, 6'd26, 3'b000);
		tick();
		wait_issue(0);
		check_station(0);
		wait_issue(1);
		check_station(1);
		ack_stations(2'b11);
	endtask

	task automatic random_round();
		logic [31:0]     rnd;
		logic [31:0]     data;
		pregno_t         p [NWB];
		logic [NWB-1:0]  wr;
		logic [NSTN-1:0] mask;
		// Writebacks avoid every register a busy station names
		tick();
		for (int w = 0; w < NWB; w++) begin
			rnd = $random(seed);
			data = $random(seed);
			p[w] = rnd[13:8];
			wr[w] = rnd[0] && p[w] != '0 && !in_use(p[w]);
			for (int o = 0; o < w; o++) begin
				if (wr[o] && p[o] == p[w]) begin
					wr[w] = 1'b0;
				end
			end
			if (wr[w]) begin
				wb_set(w, p[w], data, rnd[1]);
			end
		end
		tick();
		for (int s = 0; s < NSTN; s++) begin
			rnd = $random(seed);
			if (!st_busy[s] && rnd[1:0] != 2'b00) begin
				dispatch_set(s, rnd[7:2], rnd[13:8], rnd[19:14], rnd[22:20] & rnd[25:23]);
			end
		end
		tick();
		for (int s = 0; s < NSTN; s++) begin
			if (st_busy[s]) begin
				wait_issue(s);
				check_station(s);
			end
		end
		// Some issued stations stay held across the next round
		rnd = $random(seed);
		mask = '0;
		for (int s = 0; s < NSTN; s++) begin
			mask[s] = st_busy[s] && rnd[s];
		end
		if (mask != '0) begin
			ack_stations(mask);
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		seed = 27;
		for (int i = 0; i < NPREG; i++) begin
			model_val[i] = value_zero;
			model_tag[i] = 1'b0;
		end
		for (int s = 0; s < NSTN; s++) begin
			st_busy[s] = 1'b0;
			st_dv[s] = '0;
			for (int k = 0; k < NOPND; k++) begin
				st_preg[s][k] = '0;
			end
		end
		rst <= 1'b1;
		wb_valid <= '0;
		wb_preg <= '0;
		wb_val <= '0;
		wb_tag <= '0;
		dispatch <= '0;
		disp_preg <= '0;
		disp_valid <= '0;
		issue_ack <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_all_valid();
		test_written_regs();
		test_reg_zero();
		test_bypass_wakeup();
		test_port_contention();
		for (int r = 0; r < ROUNDS; r++) begin
			random_round();
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* verilog/operand_pkg.sv */
/*
 * Operand capture definitions
 * Register numbering, operand values and the port and slot counts shared
 * by the register file, the read-port scheduler and the operand stations
 */
package operand_pkg;

	// ======================================================================
	// Physical register file
	// ======================================================================

	// Register zero is hardwired and always reads as zero
	localparam int NPREG = 64;
	typedef logic [$clog2(NPREG)-1:0] pregno_t;

	// Operand payload, the tag bit is carried on its own wire
	localparam int VALW = 32;
	typedef logic [VALW-1:0] value_t;
	localparam value_t value_zero = '0;

	// Writeback ports double as the bypass inputs of every station
	localparam int NWB = 2;

	// Read ports shared among all pending operands
	localparam int NRP = 4;

	// ======================================================================
	// Operand stations
	// ======================================================================

	localparam int NSTN = 2;
	localparam int NOPND = 3;

	// One pending slot per source operand of every station
	localparam int NPEND = NSTN * NOPND;

	// Index of a pending slot, used for the scheduler's rotating start
	typedef logic [$clog2(NPEND)-1:0] slot_t;

endpackage

/* verilog/operand_station.sv */
/*
 * Operand station
 * Holds one dispatched instruction while its source operands are
 * collected, and raises issue once all three are valid
 */
`timescale 1ns/1ps

module operand_station (
	input  logic                                          clk_i,
	input  logic                                          rst_i,
	input  logic                                          dispatch_i,
	input  operand_pkg::pregno_t [operand_pkg::NOPND-1:0] disp_preg_i,
	input  logic [operand_pkg::NOPND-1:0]                 disp_valid_i,
	input  logic                                          issue_ack_i,
	input  operand_pkg::pregno_t [operand_pkg::NRP-1:0]   rdv_preg_i,
	input  logic [operand_pkg::NRP-1:0]                   rdv_i,
	input  operand_pkg::value_t [operand_pkg::NRP-1:0]    rd_val_i,
	input  logic [operand_pkg::NRP-1:0]                   rd_tag_i,
	input  logic [operand_pkg::NWB-1:0]                   wb_valid_i,
	input  operand_pkg::pregno_t [operand_pkg::NWB-1:0]   wb_preg_i,
	input  operand_pkg::value_t [operand_pkg::NWB-1:0]    wb_val_i,
	input  logic [operand_pkg::NWB-1:0]                   wb_tag_i,
	output logic [operand_pkg::NOPND-1:0]                 pend_o,
	output operand_pkg::pregno_t [operand_pkg::NOPND-1:0] pend_preg_o,
	output logic                                          issue_o,
	output operand_pkg::value_t [operand_pkg::NOPND-1:0]  opnd_val_o,
	output logic [operand_pkg::NOPND-1:0]                 opnd_tag_o
);
	import operand_pkg::*;

	// Station state
	logic                  busy_q;
	pregno_t [NOPND-1:0]   preg_q;
	logic [NOPND-1:0]      vld_q;
	value_t [NOPND-1:0]    val_q;
	logic [NOPND-1:0]      tag_q;

	// Results of this cycle's matching
	value_t [NOPND-1:0]    val_new;
	logic [NOPND-1:0]      tag_new;
	logic [NOPND-1:0]      vld_new;
	logic [NOPND-1:0]      cap;

	validate_operand #(
		.NBPI(NWB)
	) validate_inst (
		.prn_i     (rdv_preg_i),
		.prnv_i    (rdv_i),
		.rfo_i     (rd_val_i),
		.rfo_tag_i (rd_tag_i),
		.prn0_i    (preg_q[0]),
		.prn1_i    (preg_q[1]),
		.prn2_i    (preg_q[2]),
		.rfi_val_i (wb_val_i),
		.rfi_tag_i (wb_tag_i),
		.rfi_prd_i (wb_preg_i),
		.rfi_v_i   (wb_valid_i),
		.valid0_i  (vld_q[0]),
		.valid1_i  (vld_q[1]),
		.valid2_i  (vld_q[2]),
		.val0_o    (val_new[0]),
		.val1_o    (val_new[1]),
		.val2_o    (val_new[2]),
		.tag0_o    (tag_new[0]),
		.tag1_o    (tag_new[1]),
		.tag2_o    (tag_new[2]),
		.valid0_o  (vld_new[0]),
		.valid1_o  (vld_new[1]),
		.valid2_o  (vld_new[2])
	);

	// A valid flag that turns on marks the cycle where a source matched
	assign cap = vld_new & ~vld_q;

	// ======================================================================
	// Control state
	// ======================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			vld_q <= '0;
		end else if (dispatch_i) begin
			busy_q <= 1'b1;
			preg_q <= disp_preg_i;
			vld_q <= disp_valid_i;
		end else if (busy_q) begin
			if (issue_ack_i) begin
				busy_q <= 1'b0;
			end else begin
				vld_q <= vld_new;
			end
		end
	end

	// Operands dispatched valid carry zero, the rest fill in as they match
	always_ff @(posedge clk_i) begin
		if (dispatch_i) begin
			val_q <= '0;
			tag_q <= '0;
		end else if (busy_q && !issue_ack_i) begin
			for (int k = 0; k < NOPND; k++) begin
				if (cap[k]) begin
					val_q[k] <= val_new[k];
					tag_q[k] <= tag_new[k];
				end
			end
		end
	end

	assign pend_o = {NOPND{busy_q}} & ~vld_q;
	assign pend_preg_o = preg_q;
	assign issue_o = busy_q && (&vld_q);
	assign opnd_val_o = val_q;
	assign opnd_tag_o = tag_q;

	// The dispatcher only targets a free station
	a_disp_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		dispatch_i |-> !busy_q)
		else $error("operand_station: dispatch while busy");

endmodule

/* verilog/operand_top.sv */
/*
 * Operand capture subsystem
 * Register file, read-port scheduler and the operand stations of the
 * issue stage, wired to the writeback ports and the dispatch strobes
 */
`timescale 1ns/1ps

module operand_top (
	input  logic                                            clk_i,
	input  logic                                            rst_i,
	input  logic [operand_pkg::NWB-1:0]                     wb_valid_i,
	input  operand_pkg::pregno_t [operand_pkg::NWB-1:0]     wb_preg_i,
	input  operand_pkg::value_t [operand_pkg::NWB-1:0]      wb_val_i,
	input  logic [operand_pkg::NWB-1:0]                     wb_tag_i,
	input  logic [operand_pkg::NSTN-1:0]                    dispatch_i,
	input  operand_pkg::pregno_t [operand_pkg::NSTN-1:0][operand_pkg::NOPND-1:0] disp_preg_i,
	input  logic [operand_pkg::NSTN-1:0][operand_pkg::NOPND-1:0] disp_valid_i,
	input  logic [operand_pkg::NSTN-1:0]                    issue_ack_i,
	output logic [operand_pkg::NSTN-1:0]                    issue_o,
	output operand_pkg::value_t [operand_pkg::NSTN-1:0][operand_pkg::NOPND-1:0] opnd_val_o,
	output logic [operand_pkg::NSTN-1:0][operand_pkg::NOPND-1:0] opnd_tag_o
);
	import operand_pkg::*;

	// Read requests and their aligned returns
	pregno_t [NRP-1:0]   rd_preg;
	value_t [NRP-1:0]    rd_val;
	logic [NRP-1:0]      rd_tag;
	pregno_t [NRP-1:0]   rdv_preg;
	logic [NRP-1:0]      rdv;

	// Pending slots, station s owns slots s*NOPND up to s*NOPND+NOPND-1
	logic [NPEND-1:0]    pend;
	pregno_t [NPEND-1:0] pend_preg;

	phys_regfile regfile_inst (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wr_en_i   (wb_valid_i),
		.wr_preg_i (wb_preg_i),
		.wr_val_i  (wb_val_i),
		.wr_tag_i  (wb_tag_i),
		.rd_preg_i (rd_preg),
		.rd_val_o  (rd_val),
		.rd_tag_o  (rd_tag)
	);

	read_port_sched sched_inst (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pend_i      (pend),
		.pend_preg_i (pend_preg),
		.rd_preg_o   (rd_preg),
		.rdv_preg_o  (rdv_preg),
		.rdv_o       (rdv)
	);

	// Every station sees all read returns and the writebacks as bypass
	for (genvar s = 0; s < NSTN; s++) begin : g_stn
		operand_station station_inst (
			.clk_i        (clk_i),
			.rst_i        (rst_i),
			.dispatch_i   (dispatch_i[s]),
			.disp_preg_i  (disp_preg_i[s]),
			.disp_valid_i (disp_valid_i[s]),
			.issue_ack_i  (issue_ack_i[s]),
			.rdv_preg_i   (rdv_preg),
			.rdv_i        (rdv),
			.rd_val_i     (rd_val),
			.rd_tag_i     (rd_tag),
			.wb_valid_i   (wb_valid_i),
			.wb_preg_i    (wb_preg_i),
			.wb_val_i     (wb_val_i),
			.wb_tag_i     (wb_tag_i),
			.pend_o       (pend[s*NOPND +: NOPND]),
			.pend_preg_o  (pend_preg[s*NOPND +: NOPND]),
			.issue_o      (issue_o[s]),
			.opnd_val_o   (opnd_val_o[s]),
			.opnd_tag_o   (opnd_tag_o[s])
		);
	end

endmodule

/* verilog/phys_regfile.sv */
/*
 * Physical register file
 * Value and tag storage written by the writeback ports, with registered
 * read ports. Register zero is never written and reads as zero
 */
`timescale 1ns/1ps

module phys_regfile (
	input  logic                                          clk_i,
	input  logic                                          rst_i,
	input  logic [operand_pkg::NWB-1:0]                   wr_en_i,
	input  operand_pkg::pregno_t [operand_pkg::NWB-1:0]   wr_preg_i,
	input  operand_pkg::value_t [operand_pkg::NWB-1:0]    wr_val_i,
	input  logic [operand_pkg::NWB-1:0]                   wr_tag_i,
	input  operand_pkg::pregno_t [operand_pkg::NRP-1:0]   rd_preg_i,
	output operand_pkg::value_t [operand_pkg::NRP-1:0]    rd_val_o,
	output logic [operand_pkg::NRP-1:0]                   rd_tag_o
);
	import operand_pkg::*;

	// Storage arrays, one value and one tag bit per physical register
	value_t           mem_val [NPREG];
	logic [NPREG-1:0] mem_tag;

	// ======================================================================
	// Write side
	// ======================================================================

	// Writes land at the clock edge
	// Entry zero keeps its reset value because writes to it are dropped
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NPREG; i++) begin
				mem_val[i] <= value_zero;
			end
			mem_tag <= '0;
		end else begin
			for (int w = 0; w < NWB; w++) begin
				if (wr_en_i[w] && wr_preg_i[w] != '0) begin
					mem_val[wr_preg_i[w]] <= wr_val_i[w];
					mem_tag[wr_preg_i[w]] <= wr_tag_i[w];
				end
			end
		end
	end

	// ======================================================================
	// Read side
	// ======================================================================

	// An address presented in cycle k gives data during cycle k+1
	// A read racing a write to the same register sees the old contents,
	// the stations pick up the new value from the bypass inputs instead
	always_ff @(posedge clk_i) begin
		for (int r = 0; r < NRP; r++) begin
			rd_val_o[r] <= mem_val[rd_preg_i[r]];
			rd_tag_o[r] <= mem_tag[rd_preg_i[r]];
		end
	end

	// Two writeback ports never target the same live register in one cycle,
	// the rename logic upstream hands out each destination once
	for (genvar a = 0; a < NWB; a++) begin : g_wr_a
		for (genvar b = a + 1; b < NWB; b++) begin : g_wr_b
			a_wr_collide: assert property (@(posedge clk_i) disable iff (rst_i)
				!(wr_en_i[a] && wr_en_i[b] && wr_preg_i[a] != '0 &&
				  wr_preg_i[a] == wr_preg_i[b]))
				else $error("phys_regfile: ports %0d and %0d write p%0d together",
				            a, b, wr_preg_i[a]);
		end
	end

endmodule

/* verilog/read_port_sched.sv */
/*
 * Read-port scheduler
 * Shares the register-file read ports among pending operand slots with a
 * rotating start, and delays the picks to line up with the read data
 */
`timescale 1ns/1ps

module read_port_sched (
	input  logic                                          clk_i,
	input  logic                                          rst_i,
	input  logic [operand_pkg::NPEND-1:0]                 pend_i,
	input  operand_pkg::pregno_t [operand_pkg::NPEND-1:0] pend_preg_i,
	output operand_pkg::pregno_t [operand_pkg::NRP-1:0]   rd_preg_o,
	output operand_pkg::pregno_t [operand_pkg::NRP-1:0]   rdv_preg_o,
	output logic [operand_pkg::NRP-1:0]                   rdv_o
);
	import operand_pkg::*;

	// Rotating start slot and the slots whose read returns this cycle
	slot_t            ptr_q;
	slot_t            ptr_d;
	logic [NPEND-1:0] infl_q;
	logic [NPEND-1:0] infl_d;

	// Slots that may be read this cycle
	logic [NPEND-1:0] elig;

	// Per-port picks for the current cycle
	logic [NRP-1:0]       pick_v;
	pregno_t [NRP-1:0]    pick_preg;

	// A slot already in flight would only fetch the same data twice
	// Register zero never needs a port, the stations resolve it directly
	always_comb begin
		for (int s = 0; s < NPEND; s++) begin
			elig[s] = pend_i[s] && !infl_q[s] && (pend_preg_i[s] != '0);
		end
	end

	// ======================================================================
	// Port allocation
	// ======================================================================

	// Walk the slots once starting at the pointer and hand out ports in order
	// The pointer moves just past the last slot that won a port so a slot
	// that lost out this cycle is first in line next cycle
	always_comb begin
		int cnt;
		int slot;
		cnt = 0;
		ptr_d = ptr_q;
		infl_d = '0;
		pick_v = '0;
		pick_preg = '0;
		for (int i = 0; i < NPEND; i++) begin
			slot = int'(ptr_q) + i;
			if (slot >= NPEND) begin
				slot = slot - NPEND;
			end
			if (elig[slot] && cnt < NRP) begin
				pick_v[cnt] = 1'b1;
				pick_preg[cnt] = pend_preg_i[slot];
				infl_d[slot] = 1'b1;
				ptr_d = (slot == NPEND - 1) ? slot_t'(0) : slot_t'(slot + 1);
				cnt++;
			end
		end
	end

	// Unused ports read register zero, which is harmless
	assign rd_preg_o = pick_preg;

	// ======================================================================
	// Return alignment
	// ======================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ptr_q <= '0;
			infl_q <= '0;
			rdv_o <= '0;
		end else begin
			ptr_q <= ptr_d;
			infl_q <= infl_d;
			rdv_o <= pick_v;
		end
	end

	// The register numbers travel with the data through the same delay
	always_ff @(posedge clk_i) begin
		rdv_preg_o <= pick_preg;
	end

	// Nothing upstream ever spends a port on register zero
	for (genvar p = 0; p < NRP; p++) begin : g_chk
		a_no_zero: assert property (@(posedge clk_i) disable iff (rst_i)
			rdv_o[p] |-> rdv_preg_o[p] != '0)
			else $error("read_port_sched: port %0d returned register zero", p);
	end

endmodule

/* verilog/validate_operand.sv */
/*
 * Operand validation
 * Matches three source registers against the read returns and the
 * writeback bypass, giving each operand's value, tag and valid flag
 */
`timescale 1ns/1ps

module validate_operand #(
	// Number of bypassing inputs
	parameter int NBPI = 2
) (
	input  operand_pkg::pregno_t [operand_pkg::NRP-1:0] prn_i,
	input  logic [operand_pkg::NRP-1:0]                 prnv_i,
	input  operand_pkg::value_t [operand_pkg::NRP-1:0]  rfo_i,
	input  logic [operand_pkg::NRP-1:0]                 rfo_tag_i,
	input  operand_pkg::pregno_t                        prn0_i,
	input  operand_pkg::pregno_t                        prn1_i,
	input  operand_pkg::pregno_t                        prn2_i,
	input  operand_pkg::value_t [NBPI-1:0]              rfi_val_i,
	input  logic [NBPI-1:0]                             rfi_tag_i,
	input  operand_pkg::pregno_t [NBPI-1:0]             rfi_prd_i,
	input  logic [NBPI-1:0]                             rfi_v_i,
	input  logic                                        valid0_i,
	input  logic                                        valid1_i,
	input  logic                                        valid2_i,
	output operand_pkg::value_t                         val0_o,
	output operand_pkg::value_t                         val1_o,
	output operand_pkg::value_t                         val2_o,
	output logic                                        tag0_o,
	output logic                                        tag1_o,
	output logic                                        tag2_o,
	output logic                                        valid0_o,
	output logic                                        valid1_o,
	output logic                                        valid2_o
);
	import operand_pkg::*;

	// Operands gathered into arrays so one loop covers all three
	pregno_t [NOPND-1:0] opn;
	logic [NOPND-1:0]    vin;
	value_t [NOPND-1:0]  vsel;
	logic [NOPND-1:0]    tsel;
	logic [NOPND-1:0]    vout;

	assign opn = {prn2_i, prn1_i, prn0_i};
	assign vin = {valid2_i, valid1_i, valid0_i};

	// ======================================================================
	// Source matching
	// ======================================================================

	// Only operands that are still waiting look at any source
	// Register zero is settled on the spot and takes no port or bypass,
	// otherwise a read return matches first and a bypass overrides it
	// since the writeback is the newer copy of the register
	always_comb begin
		vout = vin;
		tsel = '0;
		for (int k = 0; k < NOPND; k++) begin
			vsel[k] = value_zero;
			if (!vin[k]) begin
				if (opn[k] == '0) begin
					vout[k] = 1'b1;
				end else begin
					for (int r = 0; r < NRP; r++) begin
						if (prnv_i[r] && prn_i[r] == opn[k]) begin
							vsel[k] = rfo_i[r];
							tsel[k] = rfo_tag_i[r];
							vout[k] = 1'b1;
						end
					end
					for (int b = 0; b < NBPI; b++) begin
						if (rfi_v_i[b] && rfi_prd_i[b] == opn[k]) begin
							vsel[k] = rfi_val_i[b];
							tsel[k] = rfi_tag_i[b];
							vout[k] = 1'b1;
						end
					end
				end
			end
		end
	end

	// Back out to the individual operand ports
	assign val0_o = vsel[0];
	assign val1_o = vsel[1];
	assign val2_o = vsel[2];
	assign tag0_o = tsel[0];
	assign tag1_o = tsel[1];
	assign tag2_o = tsel[2];
	assign valid0_o = vout[0];
	assign valid1_o = vout[1];
	assign valid2_o = vout[2];

endmodule
